// ==== Bender.yml ====
package:
  name: cache

sources:
  - logic/cache_core_pkg.sv
  - logic/cache_state_pkg.sv
  - logic/cache_tag_array.sv
  - logic/cache_lookup.sv
  - logic/cache_controller.sv
  - logic/cache_data_array.sv
  - logic/cache_top.sv
  - target: simulation
    files:
      - sim/cache_checker.sv
      - sim/cache_tb.sv

// ==== files.f ====
logic/cache_core_pkg.sv
logic/cache_state_pkg.sv
logic/cache_tag_array.sv
logic/cache_lookup.sv
logic/cache_controller.sv
logic/cache_data_array.sv
logic/cache_top.sv
sim/cache_checker.sv
sim/cache_tb.sv

// ==== logic/cache_controller.sv ====
`timescale 1ns/100ps

module cache_controller #(
    parameter int sets_p        = 4,
    parameter int block_words_p = 4,
    localparam int offset_w_lp  = $clog2(block_words_p) + 2,
    localparam int index_w_lp   = $clog2(sets_p),
    localparam int tag_w_lp     = cache_core_pkg::addr_width_c - index_w_lp - offset_w_lp
) (
    input  logic clk_i,
    input  logic nreset_i,

    input  logic cc_valid_i,
    output logic cc_ready_o,
    output logic cc_valid_o,

    input  logic                                    hit_i,
    input  logic                                    victim_dirty_i,
    input  logic                                    req_we_i,
    input  logic [cache_core_pkg::addr_width_c-1:0] req_addr_i,
    input  logic [tag_w_lp-1:0]                     victim_tag_i,

    input  logic                                    cb_yumi_i,
    input  logic                                    cb_valid_i,
    output logic                                    cb_valid_o,
    output logic                                    cb_we_o,
    output logic [cache_core_pkg::addr_width_c-1:0] cb_addr_o,

    output logic accept_o,
    output logic fill_o,
    output logic hit_write_o,
    output logic touch_o,
    output logic use_fill_word_o
);

    cache_state_pkg::ctrl_state_e state_r, state_n;

    logic [cache_core_pkg::addr_width_c-1:0] evict_addr;
    logic [cache_core_pkg::addr_width_c-1:0] fetch_addr;

    // Victim block goes back to the set of the current request
    assign evict_addr = {victim_tag_i, req_addr_i[offset_w_lp +: index_w_lp],
                         offset_w_lp'(0)};
    assign fetch_addr = {req_addr_i[cache_core_pkg::addr_width_c-1:offset_w_lp],
                         offset_w_lp'(0)};

    always_comb begin
        state_n         = state_r;
        cc_ready_o      = 1'b0;
        cc_valid_o      = 1'b0;
        cb_valid_o      = 1'b0;
        cb_we_o         = 1'b0;
        cb_addr_o       = fetch_addr;
        accept_o        = 1'b0;
        fill_o          = 1'b0;
        hit_write_o     = 1'b0;
        touch_o         = 1'b0;
        use_fill_word_o = 1'b0;
        case (state_r)
            cache_state_pkg::st_idle: begin
                cc_ready_o = 1'b1;
                accept_o   = cc_valid_i;
                if (cc_valid_i) begin
                    state_n = cache_state_pkg::st_lookup;
                end
            end
            cache_state_pkg::st_lookup: begin
                if (hit_i) begin
                    cc_valid_o  = 1'b1;
                    hit_write_o = req_we_i;
                    touch_o     = 1'b1;
                    state_n     = cache_state_pkg::st_idle;
                end else if (victim_dirty_i) begin
                    cb_valid_o = 1'b1;
                    cb_we_o    = 1'b1;
                    cb_addr_o  = evict_addr;
                    state_n    = cb_yumi_i ? cache_state_pkg::st_alloc_req
                                           : cache_state_pkg::st_alloc_tx;
                end else begin
                    // Clean miss skips straight to the block read
                    cb_valid_o = 1'b1;
                    state_n    = cb_yumi_i ? cache_state_pkg::st_alloc_rx
                                           : cache_state_pkg::st_alloc_req;
                end
            end
            cache_state_pkg::st_alloc_tx: begin
                cb_valid_o = 1'b1;
                cb_we_o    = 1'b1;
                cb_addr_o  = evict_addr;
                if (cb_yumi_i) begin
                    state_n = cache_state_pkg::st_alloc_req;
                end
            end
            cache_state_pkg::st_alloc_req: begin
                cb_valid_o = 1'b1;
                if (cb_yumi_i) begin
                    state_n = cache_state_pkg::st_alloc_rx;
                end
            end
            cache_state_pkg::st_alloc_rx: begin
                use_fill_word_o = 1'b1;
                if (cb_valid_i) begin
                    fill_o     = 1'b1;
                    touch_o    = 1'b1;
                    cc_valid_o = 1'b1;
                    state_n    = cache_state_pkg::st_idle;
                end
            end
            default: state_n = cache_state_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (nreset_i) begin
            state_r <= cache_state_pkg::st_idle;
        end else begin
            state_r <= state_n;
        end
    end

endmodule

// ==== logic/cache_core_pkg.sv ====
package cache_core_pkg;

    // Core side byte address
    localparam int addr_width_c = 32;

    // Core data word and its byte enables
    localparam int word_width_c = 32;
    localparam int be_width_c   = 4;

    // Associativity is fixed, so a way index is a single bit
    localparam int ways_c = 2;

endpackage

// ==== logic/cache_data_array.sv ====
`timescale 1ns/100ps

module cache_data_array #(
    parameter int sets_p        = 4,
    parameter int block_words_p = 4,
    localparam int word_sel_w_lp = $clog2(block_words_p),
    localparam int index_w_lp    = $clog2(sets_p),
    localparam int block_w_lp    = block_words_p * cache_core_pkg::word_width_c
) (
    input  logic                                    clk_i,
    input  logic [index_w_lp-1:0]                   set_i,
    input  logic                                    way_i,
    input  logic [cache_core_pkg::addr_width_c-1:0] req_addr_i,
    input  logic [cache_core_pkg::be_width_c-1:0]   req_be_i,
    input  logic [cache_core_pkg::word_width_c-1:0] req_wdata_i,
    input  logic                                    req_we_i,
    input  logic                                    fill_i,
    input  logic                                    hit_write_i,
    input  logic                                    use_fill_word_i,
    input  logic [block_w_lp-1:0]                   cb_data_i,
    output logic [block_w_lp-1:0]                   victim_block_o,
    output logic [cache_core_pkg::word_width_c-1:0] rdata_o
);

    logic [block_w_lp-1:0]    blocks_r [sets_p][cache_core_pkg::ways_c];
    logic [block_w_lp-1:0]    merged;
    logic [block_w_lp-1:0]    rd_src;
    logic [word_sel_w_lp-1:0] word_sel;

    assign word_sel       = req_addr_i[2 +: word_sel_w_lp];
    assign victim_block_o = blocks_r[set_i][way_i];

    // Write bytes go over the fill block or the stored one
    always_comb begin
        merged = fill_i ? cb_data_i : victim_block_o;
        if (req_we_i) begin
            for (int b = 0; b < cache_core_pkg::be_width_c; b++) begin
                if (req_be_i[b]) begin
                    merged[word_sel*cache_core_pkg::word_width_c + b*8 +: 8] =
                        req_wdata_i[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i || hit_write_i) begin
            blocks_r[set_i][way_i] <= merged;
        end
    end

    // The array is written only at the end of a fill, so the word comes off the bus
    assign rd_src  = use_fill_word_i ? cb_data_i : victim_block_o;
    assign rdata_o = req_we_i ? '0
                   : rd_src[word_sel*cache_core_pkg::word_width_c +: cache_core_pkg::word_width_c];

endmodule

// ==== logic/cache_lookup.sv ====
`timescale 1ns/100ps

module cache_lookup #(
    parameter int sets_p        = 4,
    parameter int block_words_p = 4,
    localparam int offset_w_lp  = $clog2(block_words_p) + 2,
    localparam int index_w_lp   = $clog2(sets_p),
    localparam int tag_w_lp     = cache_core_pkg::addr_width_c - index_w_lp - offset_w_lp
) (
    input  logic clk_i,
    input  logic nreset_i,
    input  logic accept_i,

    input  logic [cache_core_pkg::addr_width_c-1:0] cc_addr_i,
    input  logic                                    cc_we_i,
    input  logic [cache_core_pkg::be_width_c-1:0]   cc_be_i,
    input  logic [cache_core_pkg::word_width_c-1:0] cc_wdata_i,

    input  logic [cache_core_pkg::ways_c-1:0][tag_w_lp-1:0] tags_i,
    input  cache_state_pkg::block_state_e [cache_core_pkg::ways_c-1:0] states_i,
    input  logic                                    lru_i,

    output logic [index_w_lp-1:0]                   set_o,
    output logic [cache_core_pkg::addr_width_c-1:0] req_addr_o,
    output logic                                    req_we_o,
    output logic [cache_core_pkg::be_width_c-1:0]   req_be_o,
    output logic [cache_core_pkg::word_width_c-1:0] req_wdata_o,
    output logic                                    hit_o,
    output logic                                    way_o,
    output logic                                    victim_dirty_o,
    output logic [tag_w_lp-1:0]                     victim_tag_o
);

    logic                accept_r;
    logic                hit_n, hit_r;
    logic                way_n, way_r;
    logic                dirty_n, dirty_r;
    logic [tag_w_lp-1:0] vtag_r;
    logic [tag_w_lp-1:0] req_tag;

    always_ff @(posedge clk_i) begin
        if (nreset_i) begin
            accept_r <= 1'b0;
        end else begin
            accept_r <= accept_i;
        end
    end

    // Request payload
    always_ff @(posedge clk_i) begin
        if (accept_i) begin
            req_addr_o  <= cc_addr_i;
            req_we_o    <= cc_we_i;
            req_be_o    <= cc_be_i;
            req_wdata_o <= cc_wdata_i;
        end
    end

    assign set_o   = req_addr_o[offset_w_lp +: index_w_lp];
    assign req_tag = req_addr_o[cache_core_pkg::addr_width_c-1 -: tag_w_lp];

    // Hit way first, then a free way, then the LRU way
    always_comb begin
        hit_n = 1'b0;
        way_n = lru_i;
        for (int w = 0; w < cache_core_pkg::ways_c; w++) begin
            if (states_i[w] != cache_state_pkg::block_invalid && tags_i[w] == req_tag) begin
                hit_n = 1'b1;
            end
        end
        if (hit_n) begin
            way_n = states_i[1] != cache_state_pkg::block_invalid && tags_i[1] == req_tag;
        end else if (states_i[0] == cache_state_pkg::block_invalid) begin
            way_n = 1'b0;
        end else if (states_i[1] == cache_state_pkg::block_invalid) begin
            way_n = 1'b1;
        end
        dirty_n = ~hit_n && states_i[way_n] == cache_state_pkg::block_modified;
    end

    // Held for the rest of the miss, since a fill changes the set
    always_ff @(posedge clk_i) begin
        if (accept_r) begin
            hit_r   <= hit_n;
            way_r   <= way_n;
            dirty_r <= dirty_n;
            vtag_r  <= tags_i[way_n];
        end
    end

    assign hit_o          = accept_r ? hit_n : hit_r;
    assign way_o          = accept_r ? way_n : way_r;
    assign victim_dirty_o = accept_r ? dirty_n : dirty_r;
    assign victim_tag_o   = accept_r ? tags_i[way_n] : vtag_r;

endmodule

// ==== logic/cache_state_pkg.sv ====
package cache_state_pkg;

    // Per-block coherence state without an exclusive state
    typedef enum logic [1:0] {
        block_invalid,
        block_shared,
        block_modified
    } block_state_e;

    // Miss handling controller
    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_alloc_tx,
        st_alloc_req,
        st_alloc_rx
    } ctrl_state_e;

endpackage

// ==== logic/cache_tag_array.sv ====
`timescale 1ns/100ps

module cache_tag_array #(
    parameter int sets_p        = 4,
    parameter int block_words_p = 4,
    localparam int index_w_lp   = $clog2(sets_p),
    localparam int tag_w_lp     = cache_core_pkg::addr_width_c - index_w_lp
                                  - $clog2(block_words_p) - 2
) (
    input  logic                  clk_i,
    input  logic                  nreset_i,
    input  logic [index_w_lp-1:0] set_i,
    input  logic                  fill_i,
    input  logic                  mark_dirty_i,
    input  logic                  touch_i,
    input  logic                  way_i,
    input  logic [tag_w_lp-1:0]   fill_tag_i,
    input  logic                  fill_dirty_i,

    output logic [cache_core_pkg::ways_c-1:0][tag_w_lp-1:0] tags_o,
    output cache_state_pkg::block_state_e [cache_core_pkg::ways_c-1:0] states_o,
    output logic                  lru_o
);

    logic [cache_core_pkg::ways_c-1:0][tag_w_lp-1:0] tags_r [sets_p];
    cache_state_pkg::block_state_e [cache_core_pkg::ways_c-1:0] states_r [sets_p];
    logic [sets_p-1:0] lru_r;

    // Tag of the block that a fill installs
    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tags_r[set_i][way_i] <= fill_tag_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (nreset_i) begin
            for (int s = 0; s < sets_p; s++) begin
                for (int w = 0; w < cache_core_pkg::ways_c; w++) begin
                    states_r[s][w] <= cache_state_pkg::block_invalid;
                end
            end
            lru_r <= '0;
        end else begin
            // A write miss installs the block already modified
            if (fill_i) begin
                states_r[set_i][way_i] <= fill_dirty_i ? cache_state_pkg::block_modified
                                                       : cache_state_pkg::block_shared;
            end else if (mark_dirty_i) begin
                states_r[set_i][way_i] <= cache_state_pkg::block_modified;
            end

            // LRU bit names the way to evict next
            if (touch_i) begin
                lru_r[set_i] <= ~way_i;
            end
        end
    end

    assign tags_o   = tags_r[set_i];
    assign states_o = states_r[set_i];
    assign lru_o    = lru_r[set_i];

endmodule

// ==== logic/cache_top.sv ====
`timescale 1ns/100ps

module cache_top #(
    parameter int sets_p        = 4,
    parameter int block_words_p = 4,
    localparam int index_w_lp   = $clog2(sets_p),
    localparam int tag_w_lp     = cache_core_pkg::addr_width_c - index_w_lp
                                  - $clog2(block_words_p) - 2,
    localparam int block_w_lp   = block_words_p * cache_core_pkg::word_width_c
) (
    input  logic clk_i,
    input  logic nreset_i,

    // Core request and response
    input  logic                                    cc_valid_i,
    output logic                                    cc_ready_o,
    input  logic [cache_core_pkg::addr_width_c-1:0] cc_addr_i,
    input  logic                                    cc_we_i,
    input  logic [cache_core_pkg::be_width_c-1:0]   cc_be_i,
    input  logic [cache_core_pkg::word_width_c-1:0] cc_wdata_i,
    output logic                                    cc_valid_o,
    output logic [cache_core_pkg::word_width_c-1:0] cc_rdata_o,

    // Memory bus moving one block per beat
    output logic                                    cb_valid_o,
    input  logic                                    cb_yumi_i,
    output logic                                    cb_we_o,
    output logic [cache_core_pkg::addr_width_c-1:0] cb_addr_o,
    output logic [block_w_lp-1:0]                   cb_wdata_o,
    input  logic                                    cb_valid_i,
    input  logic [block_w_lp-1:0]                   cb_data_i
);

    logic [index_w_lp-1:0]                   set;
    logic [cache_core_pkg::addr_width_c-1:0] req_addr;
    logic                                    req_we;
    logic [cache_core_pkg::be_width_c-1:0]   req_be;
    logic [cache_core_pkg::word_width_c-1:0] req_wdata;
    logic                                    hit, way, victim_dirty, lru;
    logic [tag_w_lp-1:0]                     victim_tag;
    logic                                    accept, fill, hit_write, touch, use_fill_word;

    logic [cache_core_pkg::ways_c-1:0][tag_w_lp-1:0] tags;
    cache_state_pkg::block_state_e [cache_core_pkg::ways_c-1:0] states;

    cache_lookup #(.sets_p(sets_p), .block_words_p(block_words_p)) lookup_i (
        .clk_i, .nreset_i, .accept_i(accept),
        .cc_addr_i, .cc_we_i, .cc_be_i, .cc_wdata_i,
        .tags_i(tags), .states_i(states), .lru_i(lru),
        .set_o(set), .req_addr_o(req_addr), .req_we_o(req_we), .req_be_o(req_be),
        .req_wdata_o(req_wdata), .hit_o(hit), .way_o(way),
        .victim_dirty_o(victim_dirty), .victim_tag_o(victim_tag)
    );

    cache_controller #(.sets_p(sets_p), .block_words_p(block_words_p)) ctrl_i (
        .clk_i, .nreset_i, .cc_valid_i, .cc_ready_o, .cc_valid_o,
        .hit_i(hit), .victim_dirty_i(victim_dirty), .req_we_i(req_we),
        .req_addr_i(req_addr), .victim_tag_i(victim_tag),
        .cb_yumi_i, .cb_valid_i, .cb_valid_o, .cb_we_o, .cb_addr_o,
        .accept_o(accept), .fill_o(fill), .hit_write_o(hit_write),
        .touch_o(touch), .use_fill_word_o(use_fill_word)
    );

    // New tag comes from the request address
    cache_tag_array #(.sets_p(sets_p), .block_words_p(block_words_p)) tags_i (
        .clk_i, .nreset_i, .set_i(set), .fill_i(fill), .mark_dirty_i(hit_write),
        .touch_i(touch), .way_i(way),
        .fill_tag_i(req_addr[cache_core_pkg::addr_width_c-1 -: tag_w_lp]),
        .fill_dirty_i(req_we), .tags_o(tags), .states_o(states), .lru_o(lru)
    );

    cache_data_array #(.sets_p(sets_p), .block_words_p(block_words_p)) data_i (
        .clk_i, .set_i(set), .way_i(way), .req_addr_i(req_addr), .req_be_i(req_be),
        .req_wdata_i(req_wdata), .req_we_i(req_we), .fill_i(fill),
        .hit_write_i(hit_write), .use_fill_word_i(use_fill_word), .cb_data_i,
        .victim_block_o(cb_wdata_o), .rdata_o(cc_rdata_o)
    );

endmodule

// ==== sim/cache_checker.sv ====
`timescale 1ns/100ps

module cache_checker (
    input logic                                    clk_i,
    input logic                                    nreset_i,
    input cache_state_pkg::ctrl_state_e            state_r,
    input logic                                    hit_i,
    input logic                                    victim_dirty_i,
    input logic [cache_core_pkg::addr_width_c-1:0] req_addr_i,
    input logic                                    cb_valid_o,
    input logic                                    cb_we_o,
    input logic [cache_core_pkg::addr_width_c-1:0] cb_addr_o,
    input logic                                    cb_yumi_i,
    input logic                                    cb_valid_i
);

    int violations = 0;

    // Fill block only while the controller waits for it
    fill_in_rx: assert property (@(posedge clk_i) disable iff (nreset_i)
        cb_valid_i |-> state_r == cache_state_pkg::st_alloc_rx)
        else begin
            $error("fill block arrived outside st_alloc_rx");
            violations++;
        end

    // Lookup results stay put while a miss is handled
    miss_inputs_held: assert property (@(posedge clk_i) disable iff (nreset_i)
        state_r inside {cache_state_pkg::st_alloc_tx, cache_state_pkg::st_alloc_req,
                        cache_state_pkg::st_alloc_rx}
        |-> $stable(hit_i) && $stable(victim_dirty_i) && $stable(req_addr_i))
        else begin
            $error("lookup result changed while a miss was handled");
            violations++;
        end

    // Bus request held until yumi
    bus_held: assert property (@(posedge clk_i) disable iff (nreset_i)
        cb_valid_o && !cb_yumi_i |=> cb_valid_o && $stable(cb_we_o) && $stable(cb_addr_o))
        else begin
            $error("bus request changed before yumi");
            violations++;
        end

endmodule

bind cache_controller cache_checker checker_i (
    .clk_i(clk_i), .nreset_i(nreset_i), .state_r(state_r),
    .hit_i(hit_i), .victim_dirty_i(victim_dirty_i), .req_addr_i(req_addr_i),
    .cb_valid_o(cb_valid_o), .cb_we_o(cb_we_o), .cb_addr_o(cb_addr_o),
    .cb_yumi_i(cb_yumi_i), .cb_valid_i(cb_valid_i)
);

// ==== sim/cache_tb.sv ====
`timescale 1ns/100ps

module cache_tb;

    localparam int sets_lp            = 4;
    localparam int block_words_lp     = 4;
    localparam int block_w_lp         = block_words_lp * cache_core_pkg::word_width_c;
    localparam int fields_lp          = 6;
    localparam int max_tests_lp       = 64;
    localparam int mem_blocks_lp      = 256;
    localparam int cycles_per_test_lp = 40;

    logic                                    clk;
    logic                                    nreset;
    logic                                    cc_valid;
    logic                                    cc_ready;
    logic [cache_core_pkg::addr_width_c-1:0] cc_addr;
    logic                                    cc_we;
    logic [cache_core_pkg::be_width_c-1:0]   cc_be;
    logic [cache_core_pkg::word_width_c-1:0] cc_wdata;
    logic                                    rsp_valid;
    logic [cache_core_pkg::word_width_c-1:0] rsp_rdata;
    logic                                    bus_valid;
    logic                                    bus_yumi;
    logic                                    bus_we;
    logic [cache_core_pkg::addr_width_c-1:0] bus_addr;
    logic [block_w_lp-1:0]                   bus_wdata;
    logic                                    fill_valid;
    logic [block_w_lp-1:0]                   fill_data;

    logic [31:0]           test_mem [max_tests_lp*fields_lp];
    logic [block_w_lp-1:0] mem_r [mem_blocks_lp];
    int                    cycle_count = 0;
    int                    cycle_limit = 0;
    int                    bus_errors  = 0;

    cache_top #(.sets_p(sets_lp), .block_words_p(block_words_lp)) dut_i (
        .clk_i(clk), .nreset_i(nreset),
        .cc_valid_i(cc_valid), .cc_ready_o(cc_ready), .cc_addr_i(cc_addr),
        .cc_we_i(cc_we), .cc_be_i(cc_be), .cc_wdata_i(cc_wdata),
        .cc_valid_o(rsp_valid), .cc_rdata_o(rsp_rdata),
        .cb_valid_o(bus_valid), .cb_yumi_i(bus_yumi), .cb_we_o(bus_we),
        .cb_addr_o(bus_addr), .cb_wdata_o(bus_wdata),
        .cb_valid_i(fill_valid), .cb_data_i(fill_data)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic int block_index(input logic [31:0] addr);
        return int'(addr[11:4]);
    endfunction

    // Memory word at byte address a starts out as a ^ c0de0000
    initial begin
        for (int b = 0; b < mem_blocks_lp; b++) begin
            for (int w = 0; w < block_words_lp; w++) begin
                mem_r[b][w*32 +: 32] = 32'(b*16 + w*4) ^ 32'hc0de0000;
            end
        end
    end

    // Bus slave with random yumi delay that returns read data one cycle after yumi
    initial begin : bus_model
        int          seed_value;
        int          wait_left;
        logic        read_pending;
        logic [31:0] read_addr;
        seed_value   = $urandom(32'h42b4);
        wait_left    = -1;
        read_pending = 1'b0;
        read_addr    = '0;
        bus_yumi     = 1'b0;
        fill_valid   = 1'b0;
        fill_data    = '0;
        forever begin
            @(negedge clk);
            bus_yumi   = 1'b0;
            fill_valid = 1'b0;
            if (read_pending) begin
                fill_valid   = 1'b1;
                fill_data    = mem_r[block_index(read_addr)];
                read_pending = 1'b0;
            end else if (!nreset && bus_valid) begin
                if (wait_left < 0) begin
                    wait_left = $urandom % 4;
                end
                if (wait_left == 0) begin
                    bus_yumi  = 1'b1;
                    wait_left = -1;
                    if (bus_addr[31:12] != '0) begin
                        $display("bus address %h lies outside the modeled memory", bus_addr);
                        bus_errors++;
                    end
                    if (bus_we) begin
                        mem_r[block_index(bus_addr)] = bus_wdata;
                    end else begin
                        read_pending = 1'b1;
                        read_addr    = bus_addr;
                    end
                end else begin
                    wait_left--;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!nreset) begin
            cycle_count <= cycle_count + 1;
            if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
                $display("timeout: the cache gave no response within %0d cycles", cycle_limit);
                $display("TESTS FAILED");
                $finish;
            end
        end
    end

    // Called on a falling edge and returns on the falling edge after the response
    task automatic issue_request(input logic [31:0] addr, input logic we, input logic [3:0] be,
                                 input logic [31:0] wdata, output logic [31:0] rdata);
        while (!cc_ready) @(negedge clk);
        cc_valid = 1'b1;
        cc_addr  = addr;
        cc_we    = we;
        cc_be    = be;
        cc_wdata = wdata;
        @(negedge clk);
        cc_valid = 1'b0;
        // Response is taken on the rising edge that ends its cycle
        @(posedge clk);
        while (!rsp_valid) @(posedge clk);
        rdata = rsp_rdata;
        @(negedge clk);
    endtask

    initial begin : run_tests
        int          num_tests;
        int          pass_count;
        int          fail_count;
        int          total_errors;
        int          base;
        logic        ok;
        logic [31:0] rdata;
        nreset   = 1'b1;
        cc_valid = 1'b0;
        cc_addr  = '0;
        cc_we    = 1'b0;
        cc_be    = '0;
        cc_wdata = '0;
        pass_count = 0;
        fail_count = 0;
        for (int i = 0; i < max_tests_lp*fields_lp; i++) begin
            test_mem[i] = '1;
        end
        $readmemh("sim/cache_tests.txt", test_mem);
        num_tests = 0;
        while (num_tests < max_tests_lp && test_mem[num_tests*fields_lp] !== 32'hffffffff) begin
            num_tests++;
        end
        if (num_tests == 0) begin
            $display("no test lines were found in sim/cache_tests.txt");
            fail_count++;
        end
        cycle_limit = num_tests * cycles_per_test_lp;

        repeat (4) @(posedge clk);
        @(negedge clk);
        nreset = 1'b0;

        for (int t = 0; t < num_tests; t++) begin
            base = t * fields_lp;
            issue_request(test_mem[base+1], test_mem[base+2][0], test_mem[base+3][3:0],
                          test_mem[base+4], rdata);
            ok = (rdata === test_mem[base+5]);
            assert (ok) else begin
                $display("error at %0t ns: test %0d addr %h expected %h got %h", $time,
                         test_mem[base], test_mem[base+1], test_mem[base+5], rdata);
            end
            if (ok) begin
                pass_count++;
            end else begin
                fail_count++;
            end
            $display("test %0d %s addr %h rdata %h : %s", test_mem[base],
                     test_mem[base+2][0] ? "write" : "read ", test_mem[base+1], rdata,
                     ok ? "ok" : "mismatch");
        end

        total_errors = fail_count + bus_errors + dut_i.ctrl_i.checker_i.violations;
        $display("%0d tests, %0d passed, %0d failed, %0d bus errors, %0d assertion failures",
                 num_tests, pass_count, fail_count, bus_errors,
                 dut_i.ctrl_i.checker_i.violations);
        if (total_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== sim/cache_tests.txt ====
// Columns: test id, byte address, we, byte enables, write word, expected read word
// All values are hex, a write expects a zero read word
01 00000014 0 0 00000000 c0de0014
02 00000118 0 0 00000000 c0de0118
03 0000001c 0 0 00000000 c0de001c
04 00000024 1 3 1234abcd 00000000
05 00000024 0 0 00000000 c0deabcd
06 00000024 1 8 77000000 00000000
07 00000024 0 0 00000000 77deabcd
08 00000028 0 0 00000000 c0de0028
09 00000004 1 f deadbeef 00000000
0a 00000048 0 0 00000000 c0de0048
0b 00000088 0 0 00000000 c0de0088
0c 00000004 0 0 00000000 deadbeef
0d 00000000 0 0 00000000 c0de0000
0e 0000008c 1 5 00aa00bb 00000000
0f 000000c4 0 0 00000000 c0de00c4
10 0000008c 0 0 00000000 c0aa00bb
11 00000008 0 0 00000000 c0de0008
12 00000004 0 0 00000000 deadbeef
13 00000044 0 0 00000000 c0de0044
14 0000008c 0 0 00000000 c0aa00bb
15 00000030 1 f 11111111 00000000
16 00000074 1 c 22220000 00000000
17 000000b0 0 0 00000000 c0de00b0
18 00000030 0 0 00000000 11111111
19 00000074 0 0 00000000 22220074
1a 00000034 0 0 00000000 c0de0034
